/* execute_stage.f */
src/exec_pkg.sv
src/exec_alu.sv
src/exec_flag_unit.sv
src/exec_ldst_unit.sv
src/execute_stage.sv
tests/tb_clock_gen.sv
tests/execute_stage_assert.sv
tests/tb_execute_stage.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the execute stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log
verilator --binary --timing --assert -f execute_stage.f \
	--top-module tb_execute_stage -o sim_tb || exit 1
./obj_dir/sim_tb > sim.log 2>&1
cat sim.log
grep -q "SIMULATION FAILED" sim.log && exit 1 || exit 0

/* src/exec_alu.sv */
`timescale 1ns/100ps
`default_nettype none

module exec_alu import exec_pkg::*; (
	input wire exec_op_e op,
	input wire logic [DATA_WIDTH-1:0] src0,
	input wire logic [DATA_WIDTH-1:0] src1,
	output logic [DATA_WIDTH-1:0] result,
	output logic [FLAG_WIDTH-1:0] alu_flags
);

	logic [DATA_WIDTH:0] sum_ext;
	logic [DATA_WIDTH:0] diff_ext;
	logic [4:0] shamt;
	logic carry;
	logic overflow;
	logic sign;
	logic parity;
	logic zero;

	// Extra top bit holds carry out or borrow
	assign sum_ext = {1'b0, src0} + {1'b0, src1};
	assign diff_ext = {1'b0, src0} - {1'b0, src1};

	assign shamt = src1[4:0];

	always_comb begin
		result = '0;
		carry = 1'b0;
		overflow = 1'b0;
		case (op)
			OP_ADD: begin
				result = sum_ext[DATA_WIDTH-1:0];
				carry = sum_ext[DATA_WIDTH];
				// Same operand signs, different result sign
				overflow = (src0[DATA_WIDTH-1] == src1[DATA_WIDTH-1]) &&
					(result[DATA_WIDTH-1] != src0[DATA_WIDTH-1]);
			end
			OP_SUB: begin
				result = diff_ext[DATA_WIDTH-1:0];
				// Borrow means src0 below src1 unsigned
				carry = diff_ext[DATA_WIDTH];
				overflow = (src0[DATA_WIDTH-1] != src1[DATA_WIDTH-1]) &&
					(result[DATA_WIDTH-1] != src0[DATA_WIDTH-1]);
			end
			OP_AND: begin
				result = src0 & src1;
			end
			OP_OR: begin
				result = src0 | src1;
			end
			OP_XOR: begin
				result = src0 ^ src1;
			end
			OP_SHL: begin
				result = src0 << shamt;
			end
			OP_SHR: begin
				result = src0 >> shamt;
			end
			OP_SAR: begin
				result = $signed(src0) >>> shamt;
			end
			default: begin
				// Loads, stores and branches do not use the ALU
				result = '0;
			end
		endcase
	end

	assign sign = result[DATA_WIDTH-1];

	// Even number of ones in the low byte
	assign parity = ~^result[7:0];

	assign zero = (result == '0);

	assign alu_flags = {sign, overflow, carry, parity, zero};

endmodule

`default_nettype wire

/* src/exec_flag_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module exec_flag_unit import exec_pkg::*; (
	input wire logic iCLOCK,
	input wire logic inRESET,
	input wire logic update,
	input wire logic [FLAG_WIDTH-1:0] alu_flags,
	input wire cond_e cond,
	output logic [FLAG_WIDTH-1:0] flags,
	output logic cond_met
);

	logic flag_sign;
	logic flag_overflow;
	logic flag_carry;
	logic flag_zero;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			flags <= '0;
		end else if (update) begin
			flags <= alu_flags;
		end
	end

	assign flag_sign = flags[4];
	assign flag_overflow = flags[3];
	assign flag_carry = flags[2];
	assign flag_zero = flags[0];

	// Stored flags only, so a branch never sees its own cycle
	always_comb begin
		case (cond)
			CC_ALWAYS: cond_met = 1'b1;
			CC_EQ:     cond_met = flag_zero;
			CC_NE:     cond_met = !flag_zero;
			CC_CS:     cond_met = flag_carry;
			CC_MI:     cond_met = flag_sign;
			CC_VS:     cond_met = flag_overflow;
			default:   cond_met = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

/* src/exec_ldst_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module exec_ldst_unit import exec_pkg::*; (
	input wire logic iCLOCK,
	input wire logic inRESET,
	input wire logic flush,
	input wire logic start,
	input wire logic rw,
	input wire ldst_order_e order,
	input wire logic [DATA_WIDTH-1:0] src0,
	input wire logic [DATA_WIDTH-1:0] src1,
	input wire logic data_busy,
	input wire logic data_ack,
	input wire logic [DATA_WIDTH-1:0] data_rdata,
	output logic data_req,
	output logic data_rw,
	output logic [DATA_WIDTH-1:0] data_addr,
	output logic [3:0] data_mask,
	output ldst_order_e data_order,
	output logic [DATA_WIDTH-1:0] data_wdata,
	output logic done,
	output logic [DATA_WIDTH-1:0] load_data
);

	logic [DATA_WIDTH-1:0] addr;
	logic [3:0] lane_mask;
	logic [DATA_WIDTH-1:0] store_data;
	logic wait_ack;
	logic [7:0] byte_sel;
	logic [15:0] half_sel;

	assign addr = src0 + src1;

	always_comb begin
		case (order)
			ORD_BYTE: begin
				lane_mask = 4'b0001 << addr[1:0];
				store_data = {4{src1[7:0]}};
			end
			ORD_HALF: begin
				lane_mask = addr[1] ? 4'b1100 : 4'b0011;
				store_data = {2{src1[15:0]}};
			end
			default: begin
				lane_mask = 4'b1111;
				store_data = src1;
			end
		endcase
	end

	// Request and acknowledge tracking
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			data_req <= 1'b0;
			wait_ack <= 1'b0;
		end else if (flush) begin
			data_req <= 1'b0;
			wait_ack <= 1'b0;
		end else if (start) begin
			data_req <= 1'b1;
			wait_ack <= 1'b0;
		end else if (data_req && !data_busy) begin
			// Memory took the request
			data_req <= 1'b0;
			wait_ack <= 1'b1;
		end else if (wait_ack && data_ack) begin
			wait_ack <= 1'b0;
		end
	end

	// Held stable for the whole request
	always_ff @(posedge iCLOCK) begin
		if (start) begin
			data_rw <= rw;
			data_addr <= addr;
			data_mask <= lane_mask;
			data_order <= order;
			data_wdata <= store_data;
		end
	end

	assign done = wait_ack && data_ack;

	// Load alignment uses the latched address and size
	assign byte_sel = data_rdata[{data_addr[1:0], 3'b000} +: 8];
	assign half_sel = data_addr[1] ? data_rdata[31:16] : data_rdata[15:0];

	always_comb begin
		case (data_order)
			ORD_BYTE: load_data = {{(DATA_WIDTH-8){1'b0}}, byte_sel};
			ORD_HALF: load_data = {{(DATA_WIDTH-16){1'b0}}, half_sel};
			default:  load_data = data_rdata;
		endcase
	end

endmodule

`default_nettype wire

/* src/exec_pkg.sv */
`default_nettype none

package exec_pkg;

	// Datapath is fixed by the four byte lanes
	localparam int DATA_WIDTH = 32;

	// Flag order from high to low: sign, overflow, carry, parity, zero
	localparam int FLAG_WIDTH = 5;

	typedef enum logic [3:0] {
		OP_ADD = 4'h0,
		OP_SUB = 4'h1,
		OP_AND = 4'h2,
		OP_OR  = 4'h3,
		OP_XOR = 4'h4,
		OP_SHL = 4'h5,
		OP_SHR = 4'h6,
		OP_SAR = 4'h7,
		OP_LD  = 4'h8,
		OP_ST  = 4'h9,
		OP_BR  = 4'ha
	} exec_op_e;

	typedef enum logic [2:0] {
		CC_ALWAYS = 3'h0,
		CC_EQ     = 3'h1,
		CC_NE     = 3'h2,
		CC_CS     = 3'h3,
		CC_MI     = 3'h4,
		CC_VS     = 3'h5
	} cond_e;

	// Access size on the data port
	typedef enum logic [1:0] {
		ORD_BYTE = 2'b00,
		ORD_HALF = 2'b01,
		ORD_WORD = 2'b10
	} ldst_order_e;

	typedef enum logic [1:0] {
		ST_NORMAL = 2'h0,
		ST_LOAD   = 2'h1,
		ST_STORE  = 2'h2,
		ST_BRANCH = 2'h3
	} exec_state_e;

endpackage

`default_nettype wire

/* src/execute_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module execute_stage import exec_pkg::*; #(
	parameter int REG_ADDR_WIDTH = 5
) (
	input wire logic iCLOCK,
	input wire logic inRESET,
	input wire logic flush,
	// Instruction from decode
	input wire logic prev_valid,
	input wire exec_op_e prev_op,
	input wire cond_e prev_cond,
	input wire ldst_order_e prev_order,
	input wire logic [DATA_WIDTH-1:0] prev_src0,
	input wire logic [DATA_WIDTH-1:0] prev_src1,
	input wire logic [REG_ADDR_WIDTH-1:0] prev_dest,
	input wire logic prev_writeback,
	input wire logic prev_flag_write,
	output logic prev_lock,
	// Writeback
	output logic next_valid,
	output logic next_writeback,
	output logic [DATA_WIDTH-1:0] next_data,
	output logic [REG_ADDR_WIDTH-1:0] next_dest,
	// Branch
	output logic jump_valid,
	output logic [DATA_WIDTH-1:0] branch_addr,
	output logic [FLAG_WIDTH-1:0] flags,
	// Data memory
	output logic data_req,
	output logic data_rw,
	output logic [DATA_WIDTH-1:0] data_addr,
	output logic [DATA_WIDTH-1:0] data_wdata,
	output logic [3:0] data_mask,
	output ldst_order_e data_order,
	input wire logic data_busy,
	input wire logic data_ack,
	input wire logic [DATA_WIDTH-1:0] data_rdata
);

	exec_state_e state;

	logic accept;
	logic is_ldst;
	logic is_store;
	logic is_branch;
	logic is_alu;
	logic flag_update;
	logic cond_met;
	logic ldst_start;
	logic ldst_done;
	logic [DATA_WIDTH-1:0] alu_result;
	logic [FLAG_WIDTH-1:0] alu_flags;
	logic [DATA_WIDTH-1:0] load_data;

	assign prev_lock = (state != ST_NORMAL);

	// A flushed cycle takes nothing
	assign accept = prev_valid && !prev_lock && !flush;

	// Opcode class
	assign is_store = (prev_op == OP_ST);
	assign is_ldst = (prev_op == OP_LD) || is_store;
	assign is_branch = (prev_op == OP_BR);
	assign is_alu = !is_ldst && !is_branch;

	assign flag_update = accept && is_alu && prev_flag_write;
	assign ldst_start = accept && is_ldst;

	exec_alu u_alu (
		.op(prev_op),
		.src0(prev_src0),
		.src1(prev_src1),
		.result(alu_result),
		.alu_flags(alu_flags)
	);

	exec_flag_unit u_flag_unit (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.update(flag_update),
		.alu_flags(alu_flags),
		.cond(prev_cond),
		.flags(flags),
		.cond_met(cond_met)
	);

	exec_ldst_unit u_ldst_unit (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.flush(flush),
		.start(ldst_start),
		.rw(is_store),
		.order(prev_order),
		.src0(prev_src0),
		.src1(prev_src1),
		.data_busy(data_busy),
		.data_ack(data_ack),
		.data_rdata(data_rdata),
		.data_req(data_req),
		.data_rw(data_rw),
		.data_addr(data_addr),
		.data_mask(data_mask),
		.data_order(data_order),
		.data_wdata(data_wdata),
		.done(ldst_done),
		.load_data(load_data)
	);

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state <= ST_NORMAL;
			next_valid <= 1'b0;
			jump_valid <= 1'b0;
			next_writeback <= 1'b0;
		end else if (flush) begin
			state <= ST_NORMAL;
			next_valid <= 1'b0;
			jump_valid <= 1'b0;
		end else begin
			next_valid <= 1'b0;
			jump_valid <= 1'b0;
			case (state)
				ST_NORMAL: begin
					if (accept) begin
						if (is_ldst) begin
							state <= is_store ? ST_STORE : ST_LOAD;
							next_writeback <= prev_writeback && !is_store;
						end else if (is_branch) begin
							// Result slot still reports, without a register write
							next_valid <= 1'b1;
							next_writeback <= 1'b0;
							jump_valid <= cond_met;
							if (cond_met) begin
								state <= ST_BRANCH;
							end
						end else begin
							next_valid <= 1'b1;
							next_writeback <= prev_writeback;
						end
					end
				end
				ST_LOAD, ST_STORE: begin
					if (ldst_done) begin
						next_valid <= 1'b1;
						state <= ST_NORMAL;
					end
				end
				default: begin
					// Wait here for flush
					state <= ST_BRANCH;
				end
			endcase
		end
	end

	// Writeback and branch payload
	always_ff @(posedge iCLOCK) begin
		if (accept) begin
			next_dest <= prev_dest;
			if (is_alu) begin
				next_data <= alu_result;
			end
			if (is_branch) begin
				branch_addr <= prev_src0;
			end
		end else if (state == ST_LOAD && ldst_done) begin
			next_data <= load_data;
		end
	end

endmodule

`default_nettype wire

/* tests/execute_stage_assert.sv */
`timescale 1ns/100ps
`default_nettype none

module execute_stage_assert import exec_pkg::*; (
	input wire logic iCLOCK,
	input wire logic inRESET,
	input wire logic flush,
	input wire logic next_valid,
	input wire logic jump_valid,
	input wire logic prev_lock,
	input wire logic data_req,
	input wire logic data_busy,
	input wire logic data_rw,
	input wire logic [DATA_WIDTH-1:0] data_addr,
	input wire logic [DATA_WIDTH-1:0] data_wdata,
	input wire logic [3:0] data_mask,
	input wire ldst_order_e data_order,
	input wire exec_state_e state
);

	// Single-cycle pulses
	assert property (@(posedge iCLOCK) disable iff (!inRESET) next_valid |=> !next_valid)
		else $error("next_valid held longer than one cycle");

	assert property (@(posedge iCLOCK) disable iff (!inRESET) jump_valid |=> !jump_valid)
		else $error("jump_valid held longer than one cycle");

	// Request held while memory is busy
	assert property (@(posedge iCLOCK) disable iff (!inRESET)
		(data_req && data_busy && !flush) |=> (data_req && $stable(data_rw) &&
		$stable(data_addr) && $stable(data_wdata) && $stable(data_mask) &&
		$stable(data_order)))
		else $error("memory request changed while busy");

	// Lock only drops with flush or when the instruction reports
	assert property (@(posedge iCLOCK) disable iff (!inRESET)
		(state != ST_NORMAL && !flush) |=> (prev_lock || next_valid))
		else $error("prev_lock dropped before the instruction ended");

endmodule

bind execute_stage execute_stage_assert u_execute_stage_assert (
	.iCLOCK(iCLOCK),
	.inRESET(inRESET),
	.flush(flush),
	.next_valid(next_valid),
	.jump_valid(jump_valid),
	.prev_lock(prev_lock),
	.data_req(data_req),
	.data_busy(data_busy),
	.data_rw(data_rw),
	.data_addr(data_addr),
	.data_wdata(data_wdata),
	.data_mask(data_mask),
	.data_order(data_order),
	.state(state)
);

`default_nettype wire

/* tests/tb_clock_gen.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
	output logic iCLOCK,
	output logic inRESET
);

	// 4 ns period
	initial begin
		iCLOCK = 1'b0;
		forever #2 iCLOCK = ~iCLOCK;
	end

	// Reset held for four cycles
	initial begin
		inRESET = 1'b0;
		repeat (4) @(posedge iCLOCK);
		#1 inRESET = 1'b1;
	end

endmodule

`default_nettype wire

/* tests/tb_execute_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_execute_stage import exec_pkg::*;;

	localparam int NUM_TESTS = 25;
	localparam int RESET_CYCLES = 4;
	localparam int CYCLE_LIMIT = 40 * NUM_TESTS + RESET_CYCLES;

	typedef struct {
		exec_op_e op;
		cond_e cond;
		ldst_order_e order;
		logic [31:0] src0;
		logic [31:0] src1;
		logic [4:0] dest;
		logic wb;
		logic fw;
		logic [31:0] exp_data;
		logic exp_jump;
		logic [4:0] exp_flags;
	} entry_t;

	wire logic iCLOCK;
	wire logic inRESET;
	logic flush;
	logic prev_valid;
	exec_op_e prev_op;
	cond_e prev_cond;
	ldst_order_e prev_order;
	logic [31:0] prev_src0;
	logic [31:0] prev_src1;
	logic [4:0] prev_dest;
	logic prev_writeback;
	logic prev_flag_write;
	logic prev_lock;
	logic next_valid;
	logic next_writeback;
	logic [31:0] next_data;
	logic [4:0] next_dest;
	logic jump_valid;
	logic [31:0] branch_addr;
	logic [4:0] flags;
	logic data_req;
	logic data_rw;
	logic [31:0] data_addr;
	logic [31:0] data_wdata;
	logic [3:0] data_mask;
	ldst_order_e data_order;
	logic data_busy;
	logic data_ack;
	logic [31:0] data_rdata;

	entry_t tests [0:NUM_TESTS-1];
	logic [31:0] mem [0:15];
	logic [31:0] lfsr;
	logic [31:0] exp_addr;
	logic [31:0] exp_wdata;
	logic [3:0] exp_mask;
	ldst_order_e exp_order;
	logic exp_rw;
	int errors;
	int cycles;
	int fill;

	tb_clock_gen u_clock_gen (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET)
	);

	execute_stage #(.REG_ADDR_WIDTH(5)) u_execute_stage (.*);

	function automatic logic [31:0] next_lfsr(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	task automatic random_bits(output logic [1:0] value);
		int k;
		value = '0;
		for (k = 0; k < 2; k++) begin
			value = {value[0], lfsr[0]};
			lfsr = next_lfsr(lfsr);
		end
	endtask

	// Lanes from access size and low address bits
	function automatic logic [3:0] lane_mask_for(input ldst_order_e ord, input logic [1:0] a);
		logic [3:0] m;
		int lane;
		for (lane = 0; lane < 4; lane++) begin
			case (ord)
				ORD_BYTE: m[lane] = (lane == a);
				ORD_HALF: m[lane] = ((lane / 2) == a[1]);
				default:  m[lane] = 1'b1;
			endcase
		end
		return m;
	endfunction

	// Each lane gets the byte it would hold for that access size
	function automatic logic [31:0] store_data_for(input ldst_order_e ord, input logic [31:0] s);
		logic [31:0] d;
		int lane;
		for (lane = 0; lane < 4; lane++) begin
			case (ord)
				ORD_BYTE: d[lane*8 +: 8] = s[7:0];
				ORD_HALF: d[lane*8 +: 8] = s[(lane % 2)*8 +: 8];
				default:  d[lane*8 +: 8] = s[lane*8 +: 8];
			endcase
		end
		return d;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("FAIL %s got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic set_entry(input int n, input exec_op_e op, input cond_e cc,
		input ldst_order_e ord, input logic [31:0] s0, input logic [31:0] s1,
		input logic [4:0] dest, input logic wb, input logic fw, input logic [31:0] exp_data,
		input logic exp_jump, input logic [4:0] exp_flags);
		tests[n] = '{op, cc, ord, s0, s1, dest, wb, fw, exp_data, exp_jump, exp_flags};
	endtask

	task automatic apply_entry(input int n);
		entry_t e;
		int waited;
		int errs_before;
		logic exp_wb;
		e = tests[n];
		errs_before = errors;
		exp_addr = e.src0 + e.src1;
		exp_mask = lane_mask_for(e.order, exp_addr[1:0]);
		exp_wdata = store_data_for(e.order, e.src1);
		exp_order = e.order;
		exp_rw = (e.op == OP_ST);
		exp_wb = e.wb && (e.op != OP_ST) && (e.op != OP_BR);
		prev_op = e.op;
		prev_cond = e.cond;
		prev_order = e.order;
		prev_src0 = e.src0;
		prev_src1 = e.src1;
		prev_dest = e.dest;
		prev_writeback = e.wb;
		prev_flag_write = e.fw;
		prev_valid = 1'b1;
		@(posedge iCLOCK);
		#1 prev_valid = 1'b0;
		waited = 1;
		while (!next_valid) begin
			@(posedge iCLOCK);
			#1 waited++;
		end
		if (e.op != OP_LD && e.op != OP_ST)
			check_value("latency", 32'(waited), 32'd1);
		check_value("next_writeback", 32'(next_writeback), 32'(exp_wb));
		if (exp_wb) begin
			check_value("next_data", next_data, e.exp_data);
			check_value("next_dest", 32'(next_dest), 32'(e.dest));
		end
		check_value("flags", 32'(flags), 32'(e.exp_flags));
		check_value("jump_valid", 32'(jump_valid), 32'(e.exp_jump));
		if (e.exp_jump) begin
			check_value("branch_addr", branch_addr, e.src0);
			repeat (3) begin
				@(posedge iCLOCK);
				#1 check_value("prev_lock", 32'(prev_lock), 32'd1);
			end
			flush = 1'b1;
			@(posedge iCLOCK);
			#1 flush = 1'b0;
		end
		check_value("prev_lock", 32'(prev_lock), 32'd0);
		// Idle cycle keeps next_valid a single pulse
		@(posedge iCLOCK);
		#1;
		$display("test %0d %s %s", n, e.op.name(), (errors == errs_before) ? "ok" : "FAIL");
	endtask

	// Data memory with random busy and acknowledge delays
	initial begin
		logic [1:0] busy_cycles;
		logic [1:0] ack_delay;
		logic [31:0] word;
		int lane;
		data_busy = 1'b0;
		data_ack = 1'b0;
		data_rdata = '0;
		for (fill = 0; fill < 16; fill++)
			mem[fill] = {16'(fill * 4) ^ 16'hc3c3, ~16'(fill * 4)};
		forever begin
			@(posedge iCLOCK);
			#1;
			if (data_req) begin
				check_value("data_addr", data_addr, exp_addr);
				check_value("data_mask", 32'(data_mask), 32'(exp_mask));
				check_value("data_order", 32'(data_order), 32'(exp_order));
				check_value("data_rw", 32'(data_rw), 32'(exp_rw));
				if (data_rw)
					check_value("data_wdata", data_wdata, exp_wdata);
				random_bits(busy_cycles);
				random_bits(ack_delay);
				data_busy = (busy_cycles != 0);
				repeat (busy_cycles) begin
					@(posedge iCLOCK);
					#1;
				end
				data_busy = 1'b0;
				word = mem[data_addr[5:2]];
				if (data_rw) begin
					for (lane = 0; lane < 4; lane++)
						if (data_mask[lane])
							word[lane*8 +: 8] = data_wdata[lane*8 +: 8];
					mem[data_addr[5:2]] = word;
				end
				@(posedge iCLOCK);
				#1 check_value("data_req", 32'(data_req), 32'd0);
				repeat (ack_delay) begin
					@(posedge iCLOCK);
					#1;
				end
				data_rdata = word;
				data_ack = 1'b1;
				@(posedge iCLOCK);
				#1 data_ack = 1'b0;
			end
		end
	end

	always @(posedge iCLOCK) begin
		cycles++;
		if (cycles > CYCLE_LIMIT) begin
			$display("Timeout: the DUT gave no writeback within %0d cycles", CYCLE_LIMIT);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	initial begin
		int i;
		errors = 0;
		cycles = 0;
		lfsr = 32'h1d0a0d5e;
		flush = 1'b0;
		prev_valid = 1'b0;
		prev_op = OP_ADD;
		prev_cond = CC_ALWAYS;
		prev_order = ORD_WORD;
		prev_src0 = '0;
		prev_src1 = '0;
		prev_dest = '0;
		prev_writeback = 1'b0;
		prev_flag_write = 1'b0;
		exp_addr = '0;
		exp_wdata = '0;
		exp_mask = '0;
		exp_order = ORD_WORD;
		exp_rw = 1'b0;
		// Flags are sign, overflow, carry, parity, zero
		set_entry(0, OP_ADD, CC_ALWAYS, ORD_WORD, 32'd5, 32'd3, 5'd1, 1, 1, 32'd8, 0, 5'b00000);
		set_entry(1, OP_ADD, CC_ALWAYS, ORD_WORD, 32'hffffffff, 32'd1, 5'd2, 1, 1, 32'd0, 0,
			5'b00111);
		set_entry(2, OP_ADD, CC_ALWAYS, ORD_WORD, 32'h7fffffff, 32'd1, 5'd3, 1, 1,
			32'h80000000, 0, 5'b11010);
		set_entry(3, OP_SUB, CC_ALWAYS, ORD_WORD, 32'd3, 32'd5, 5'd4, 1, 1, 32'hfffffffe, 0,
			5'b10100);
		set_entry(4, OP_SUB, CC_ALWAYS, ORD_WORD, 32'h80000000, 32'd1, 5'd5, 1, 1,
			32'h7fffffff, 0, 5'b01010);
		set_entry(5, OP_AND, CC_ALWAYS, ORD_WORD, 32'hf0f000ff, 32'h0ff00f0f, 5'd6, 1, 1,
			32'h00f0000f, 0, 5'b00010);
		set_entry(6, OP_OR, CC_ALWAYS, ORD_WORD, 32'h12000000, 32'h34, 5'd7, 1, 1,
			32'h12000034, 0, 5'b00000);
		set_entry(7, OP_XOR, CC_ALWAYS, ORD_WORD, 32'haaaaaaaa, 32'haaaaaaaa, 5'd8, 1, 1,
			32'd0, 0, 5'b00011);
		set_entry(8, OP_SHL, CC_ALWAYS, ORD_WORD, 32'd1, 32'h3f, 5'd9, 1, 1, 32'h80000000, 0,
			5'b10010);
		set_entry(9, OP_SHR, CC_ALWAYS, ORD_WORD, 32'h80000000, 32'd4, 5'd10, 1, 1,
			32'h08000000, 0, 5'b00010);
		set_entry(10, OP_SAR, CC_ALWAYS, ORD_WORD, 32'h80000000, 32'd4, 5'd11, 1, 1,
			32'hf8000000, 0, 5'b10010);
		// No flag write, flags stay
		set_entry(11, OP_ADD, CC_ALWAYS, ORD_WORD, 32'h10, 32'h20, 5'd12, 1, 0, 32'h30, 0,
			5'b10010);
		set_entry(12, OP_SUB, CC_ALWAYS, ORD_WORD, 32'd7, 32'd7, 5'd13, 1, 1, 32'd0, 0,
			5'b00011);
		set_entry(13, OP_BR, CC_EQ, ORD_WORD, 32'h400, 32'd0, 5'd0, 0, 0, 32'd0, 1, 5'b00011);
		set_entry(14, OP_BR, CC_NE, ORD_WORD, 32'h500, 32'd0, 5'd0, 0, 0, 32'd0, 0, 5'b00011);
		set_entry(15, OP_BR, CC_CS, ORD_WORD, 32'h540, 32'd0, 5'd0, 0, 0, 32'd0, 0, 5'b00011);
		set_entry(16, OP_ADD, CC_ALWAYS, ORD_WORD, 32'hffffffff, 32'd2, 5'd14, 1, 1, 32'd1, 0,
			5'b00100);
		set_entry(17, OP_BR, CC_CS, ORD_WORD, 32'h600, 32'd0, 5'd0, 0, 0, 32'd0, 1, 5'b00100);
		set_entry(18, OP_BR, CC_MI, ORD_WORD, 32'h700, 32'd0, 5'd0, 0, 0, 32'd0, 0, 5'b00100);
		// Store then load the same address in each size
		set_entry(19, OP_ST, CC_ALWAYS, ORD_WORD, 32'h10 - 32'h11223344, 32'h11223344, 5'd0,
			0, 0, 32'd0, 0, 5'b00100);
		set_entry(20, OP_LD, CC_ALWAYS, ORD_WORD, 32'h10, 32'd0, 5'd15, 1, 0, 32'h11223344, 0,
			5'b00100);
		set_entry(21, OP_ST, CC_ALWAYS, ORD_HALF, 32'h16 - 32'hbeef, 32'hbeef, 5'd0, 0, 0,
			32'd0, 0, 5'b00100);
		set_entry(22, OP_LD, CC_ALWAYS, ORD_HALF, 32'h16, 32'd0, 5'd16, 1, 0, 32'h0000beef, 0,
			5'b00100);
		set_entry(23, OP_ST, CC_ALWAYS, ORD_BYTE, 32'h1b - 32'h7e, 32'h7e, 5'd0, 0, 0, 32'd0, 0,
			5'b00100);
		set_entry(24, OP_LD, CC_ALWAYS, ORD_BYTE, 32'h1b, 32'd0, 5'd17, 1, 0, 32'h0000007e, 0,
			5'b00100);
		@(posedge inRESET);
		@(posedge iCLOCK);
		#1;
		check_value("prev_lock", 32'(prev_lock), 32'd0);
		check_value("next_valid", 32'(next_valid), 32'd0);
		check_value("jump_valid", 32'(jump_valid), 32'd0);
		check_value("data_req", 32'(data_req), 32'd0);
		check_value("flags", 32'(flags), 32'd0);
		$display("reset check %s", (errors == 0) ? "ok" : "FAIL");
		for (i = 0; i < NUM_TESTS; i++)
			apply_entry(i);
		$display("tests %0d errors %0d", NUM_TESTS, errors);
		if (errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
